// File: verilog/lpif_link_pkg.sv
package lpif_link_pkg;

  ////////////////////////////////////////////////////////////
  // Field widths and lane geometry

  localparam int STATE_WIDTH  = 4;
  localparam int PROTID_WIDTH = 2;
  localparam int DATA_WIDTH   = 64;
  localparam int CRC_WIDTH    = 16;
  localparam int DELAY_WIDTH  = 16;
  localparam int DEBUG_WIDTH  = 16;

  localparam int NUM_LANES    = 3;
  localparam int LANE_WIDTH   = 32;
  // Top bit of each lane word is the strobe
  localparam int STB_BIT      = LANE_WIDTH - 1;
  localparam int LANE_PAYLOAD = LANE_WIDTH - 1;

  ////////////////////////////////////////////////////////////
  // LPIF field types

  typedef logic [STATE_WIDTH-1:0]  lpif_state_t;
  typedef logic [PROTID_WIDTH-1:0] lpif_protid_t;
  typedef logic [DATA_WIDTH-1:0]   lpif_data_t;
  typedef logic [CRC_WIDTH-1:0]    lpif_crc_t;

  // Valid sits in bit 0
  typedef struct packed {
    lpif_state_t  state;
    lpif_protid_t protid;
    lpif_data_t   data;
    logic         dvalid;
    lpif_crc_t    crc;
    logic         crc_valid;
    logic         valid;
  } lpif_flit_t;

  localparam int FLIT_WIDTH   = $bits(lpif_flit_t);
  localparam int STRIPE_WIDTH = NUM_LANES * LANE_PAYLOAD;
  // Unused tail of lane 2, always sent as zero
  localparam int SPARE_BITS   = STRIPE_WIDTH - FLIT_WIDTH;

  ////////////////////////////////////////////////////////////
  // PHY, config and status types

  typedef logic [LANE_WIDTH-1:0]  lane_word_t;
  typedef logic [DELAY_WIDTH-1:0] delay_t;
  typedef logic [DEBUG_WIDTH-1:0] debug_cnt_t;

  typedef enum logic [1:0] {
    SYNC_OFFLINE,
    SYNC_WAIT,
    SYNC_ONLINE
  } sync_state_t;

  // Debug counters stick at all ones
  function automatic debug_cnt_t sat_inc(input debug_cnt_t cnt);
    debug_cnt_t next_cnt;
    next_cnt = (cnt == '1) ? cnt : cnt + 1'b1;
    return next_cnt;
  endfunction

endpackage

// File: verilog/lpif_online_delay.sv
`timescale 1ns/100ps

module lpif_online_delay (
  input  logic                  clk_wr,
  input  logic                  rst,
  input  logic                  online,
  input  lpif_link_pkg::delay_t delay_value,
  output logic                  online_delayed
);

  import lpif_link_pkg::*;

  sync_state_t state;
  delay_t      count;

  ////////////////////////////////////////////////////////////
  // Online sync FSM

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      state <= SYNC_OFFLINE;
      count <= '0;
    end else if (!online) begin
      // Any low sample drops the link at once
      state <= SYNC_OFFLINE;
      count <= '0;
    end else begin
      case (state)
        SYNC_OFFLINE: begin
          count <= delay_value;
          if (delay_value == '0) begin
            state <= SYNC_ONLINE;
          end else begin
            state <= SYNC_WAIT;
          end
        end
        SYNC_WAIT: begin
          // Last wait cycle when the count reaches one
          if (count <= delay_t'(1)) begin
            state <= SYNC_ONLINE;
          end else begin
            count <= count - 1'b1;
          end
        end
        SYNC_ONLINE: begin
          state <= SYNC_ONLINE;
        end
        default: begin
          state <= SYNC_OFFLINE;
        end
      endcase
    end
  end

  assign online_delayed = (state == SYNC_ONLINE);

  ////////////////////////////////////////////////////////////
  // Checks

  // No stale online level after the input dropped
  a_offline_drop: assert property (
    @(posedge clk_wr) disable iff (rst)
    !online |=> !online_delayed
  );

endmodule

// File: verilog/lpif_frame.sv
`timescale 1ns/100ps

module lpif_frame (
  input  logic                        clk_wr,
  input  logic                        rst,

  // Downstream LPIF channel
  input  lpif_link_pkg::lpif_state_t  dstrm_state,
  input  lpif_link_pkg::lpif_protid_t dstrm_protid,
  input  lpif_link_pkg::lpif_data_t   dstrm_data,
  input  logic                        dstrm_dvalid,
  input  lpif_link_pkg::lpif_crc_t    dstrm_crc,
  input  logic                        dstrm_crc_valid,
  input  logic                        dstrm_valid,

  // Transmit side towards the striper
  output lpif_link_pkg::lpif_flit_t   tx_flit,
  output lpif_link_pkg::debug_cnt_t   tx_debug_status,

  // Receive side from the striper
  input  lpif_link_pkg::lpif_flit_t   rx_flit,

  // Upstream LPIF channel
  output lpif_link_pkg::lpif_state_t  ustrm_state,
  output lpif_link_pkg::lpif_protid_t ustrm_protid,
  output lpif_link_pkg::lpif_data_t   ustrm_data,
  output logic                        ustrm_dvalid,
  output lpif_link_pkg::lpif_crc_t    ustrm_crc,
  output logic                        ustrm_crc_valid,
  output logic                        ustrm_valid
);

  import lpif_link_pkg::*;

  ////////////////////////////////////////////////////////////
  // Downstream framing

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_flit <= '0;
    end else begin
      tx_flit.state     <= dstrm_state;
      tx_flit.protid    <= dstrm_protid;
      tx_flit.data      <= dstrm_data;
      tx_flit.dvalid    <= dstrm_dvalid;
      tx_flit.crc       <= dstrm_crc;
      tx_flit.crc_valid <= dstrm_crc_valid;
      tx_flit.valid     <= dstrm_valid;
    end
  end

  // Flits sent, counted as they enter the link
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_debug_status <= '0;
    end else if (dstrm_valid) begin
      tx_debug_status <= sat_inc(tx_debug_status);
    end
  end

  ////////////////////////////////////////////////////////////
  // Upstream unpacking

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      ustrm_valid     <= 1'b0;
      ustrm_dvalid    <= 1'b0;
      ustrm_crc_valid <= 1'b0;
    end else begin
      ustrm_valid     <= rx_flit.valid;
      ustrm_dvalid    <= rx_flit.dvalid;
      ustrm_crc_valid <= rx_flit.crc_valid;
    end
  end

  // Payload fields only
  always_ff @(posedge clk_wr) begin
    ustrm_state  <= rx_flit.state;
    ustrm_protid <= rx_flit.protid;
    ustrm_data   <= rx_flit.data;
    ustrm_crc    <= rx_flit.crc;
  end

  // Qualifiers are dropped upstream in the striper when valid is clear
  a_qualifiers_need_valid: assert property (
    @(posedge clk_wr) disable iff (rst)
    !ustrm_valid |-> (!ustrm_dvalid && !ustrm_crc_valid)
  );

endmodule

// File: verilog/lpif_lane_stripe.sv
`timescale 1ns/100ps

module lpif_lane_stripe (
  input  logic                      clk_wr,
  input  logic                      rst,

  // Transmit side
  input  logic                      tx_online,
  input  lpif_link_pkg::lpif_flit_t tx_flit,
  output lpif_link_pkg::lane_word_t tx_phy0,
  output lpif_link_pkg::lane_word_t tx_phy1,
  output lpif_link_pkg::lane_word_t tx_phy2,

  // Receive side
  input  logic                      rx_online,
  input  lpif_link_pkg::lane_word_t rx_phy0,
  input  lpif_link_pkg::lane_word_t rx_phy1,
  input  lpif_link_pkg::lane_word_t rx_phy2,
  output lpif_link_pkg::lpif_flit_t rx_flit,
  output lpif_link_pkg::debug_cnt_t rx_debug_status
);

  import lpif_link_pkg::*;

  logic [STRIPE_WIDTH-1:0]    tx_stripe;
  lane_word_t [NUM_LANES-1:0] tx_next;
  lane_word_t [NUM_LANES-1:0] tx_lane;

  lane_word_t [NUM_LANES-1:0] rx_lane;
  logic [STRIPE_WIDTH-1:0]    rx_stripe;
  logic [NUM_LANES-1:0]       rx_stb;
  logic                       rx_accept;
  lpif_flit_t                 rx_next;

  ////////////////////////////////////////////////////////////
  // Transmit striping

  // Flit in the low bits, spare tail of lane 2 zero
  assign tx_stripe = {{SPARE_BITS{1'b0}}, tx_flit};

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      tx_next[i] = '0;
      if (tx_online) begin
        tx_next[i][STB_BIT]          = 1'b1;
        tx_next[i][LANE_PAYLOAD-1:0] = tx_stripe[i*LANE_PAYLOAD +: LANE_PAYLOAD];
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_lane <= '0;
    end else begin
      tx_lane <= tx_next;
    end
  end

  assign tx_phy0 = tx_lane[0];
  assign tx_phy1 = tx_lane[1];
  assign tx_phy2 = tx_lane[2];

  ////////////////////////////////////////////////////////////
  // Receive destriping

  assign rx_lane = {rx_phy2, rx_phy1, rx_phy0};

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      rx_stb[i] = rx_lane[i][STB_BIT];
      rx_stripe[i*LANE_PAYLOAD +: LANE_PAYLOAD] = rx_lane[i][LANE_PAYLOAD-1:0];
    end
  end

  // Every lane must carry its strobe
  assign rx_accept = rx_online && (&rx_stb);

  always_comb begin
    rx_next = '0;
    if (rx_accept) begin
      rx_next = lpif_flit_t'(rx_stripe[FLIT_WIDTH-1:0]);
      // A word with valid clear carries no data or crc
      rx_next.dvalid    = rx_next.dvalid & rx_next.valid;
      rx_next.crc_valid = rx_next.crc_valid & rx_next.valid;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_flit <= '0;
    end else begin
      rx_flit <= rx_next;
    end
  end

  // Online cycles with at least one strobe missing
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_debug_status <= '0;
    end else if (rx_online && !(&rx_stb)) begin
      rx_debug_status <= sat_inc(rx_debug_status);
    end
  end

endmodule

// File: verilog/lpif_link_top.sv
`timescale 1ns/100ps

module lpif_link_top (
  input  logic                        clk_wr,
  input  logic                        rst,

  // Control
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  lpif_link_pkg::delay_t       delay_x_value,
  input  lpif_link_pkg::delay_t       delay_z_value,

  // PHY lanes
  output lpif_link_pkg::lane_word_t   tx_phy0,
  output lpif_link_pkg::lane_word_t   tx_phy1,
  output lpif_link_pkg::lane_word_t   tx_phy2,
  input  lpif_link_pkg::lane_word_t   rx_phy0,
  input  lpif_link_pkg::lane_word_t   rx_phy1,
  input  lpif_link_pkg::lane_word_t   rx_phy2,

  // Downstream channel
  input  lpif_link_pkg::lpif_state_t  dstrm_state,
  input  lpif_link_pkg::lpif_protid_t dstrm_protid,
  input  lpif_link_pkg::lpif_data_t   dstrm_data,
  input  logic                        dstrm_dvalid,
  input  lpif_link_pkg::lpif_crc_t    dstrm_crc,
  input  logic                        dstrm_crc_valid,
  input  logic                        dstrm_valid,

  // Upstream channel
  output lpif_link_pkg::lpif_state_t  ustrm_state,
  output lpif_link_pkg::lpif_protid_t ustrm_protid,
  output lpif_link_pkg::lpif_data_t   ustrm_data,
  output logic                        ustrm_dvalid,
  output lpif_link_pkg::lpif_crc_t    ustrm_crc,
  output logic                        ustrm_crc_valid,
  output logic                        ustrm_valid,

  // Debug status
  output lpif_link_pkg::debug_cnt_t   tx_downstream_debug_status,
  output lpif_link_pkg::debug_cnt_t   rx_upstream_debug_status
);

  import lpif_link_pkg::*;

  logic       tx_online_delay;
  logic       rx_online_delay;
  lpif_flit_t tx_flit;
  lpif_flit_t rx_flit;

  ////////////////////////////////////////////////////////////
  // Online delay

  // Transmit waits delay_z cycles
  lpif_online_delay u_tx_sync (
    .clk_wr         (clk_wr),
    .rst            (rst),
    .online         (tx_online),
    .delay_value    (delay_z_value),
    .online_delayed (tx_online_delay)
  );

  // Receive waits delay_x cycles
  lpif_online_delay u_rx_sync (
    .clk_wr         (clk_wr),
    .rst            (rst),
    .online         (rx_online),
    .delay_value    (delay_x_value),
    .online_delayed (rx_online_delay)
  );

  ////////////////////////////////////////////////////////////
  // LPIF framing

  lpif_frame u_frame (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_flit         (tx_flit),
    .tx_debug_status (tx_downstream_debug_status),
    .rx_flit         (rx_flit),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  ////////////////////////////////////////////////////////////
  // PHY lanes

  lpif_lane_stripe u_stripe (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online_delay),
    .tx_flit         (tx_flit),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .tx_phy2         (tx_phy2),
    .rx_online       (rx_online_delay),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .rx_phy2         (rx_phy2),
    .rx_flit         (rx_flit),
    .rx_debug_status (rx_upstream_debug_status)
  );

endmodule

// File: test/lpif_link_tb.sv
`timescale 1ns/100ps

module lpif_link_tb;

  import lpif_link_pkg::*;

  localparam time CLK_PERIOD   = 40ns;
  localparam int  RESET_CYCLES = 4;
  // Whole test sequence is under 100 cycles
  localparam int  MAX_CYCLES   = 2000;
  // dstrm to ustrm through the loopback
  localparam int  LINK_LATENCY = 4;
  localparam int  TX_DELAY     = 5;
  localparam int  RX_DELAY     = 3;
  // Receiver comes up late, so its own delay still holds back the first strobes
  localparam int  RX_RISE      = 4;
  // Lane words reach the receiver 2 cycles after their flit is driven
  localparam int  FAULT_START  = 5;
  localparam int  FAULT_LEN    = 3;
  localparam int  DROP_AT      = 4;
  localparam int  RISE_AT      = 8;

  logic         clk_wr;
  logic         rst;
  logic         tx_online;
  logic         rx_online;
  delay_t       delay_x_value;
  delay_t       delay_z_value;
  lane_word_t   tx_phy0;
  lane_word_t   tx_phy1;
  lane_word_t   tx_phy2;
  lane_word_t   rx_phy0;
  lane_word_t   rx_phy1;
  lane_word_t   rx_phy2;
  lpif_flit_t   dstrm;
  lpif_state_t  ustrm_state;
  lpif_protid_t ustrm_protid;
  lpif_data_t   ustrm_data;
  logic         ustrm_dvalid;
  lpif_crc_t    ustrm_crc;
  logic         ustrm_crc_valid;
  logic         ustrm_valid;
  lpif_flit_t   ustrm;
  debug_cnt_t   tx_downstream_debug_status;
  debug_cnt_t   rx_upstream_debug_status;

  logic         fault_lane1;
  int           seed;
  int           errors;
  int           checks;
  int           sent_valid;
  int           cycle_count = 0;
  lpif_flit_t   exp_q[$];
  // Last two flits driven, for the lane checks
  lpif_flit_t   prev_flit;
  lpif_flit_t   older_flit;

  assign ustrm = {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
                  ustrm_crc, ustrm_crc_valid, ustrm_valid};

  // PHY loopback, fault clears the lane 1 strobe
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = fault_lane1 ? {1'b0, tx_phy1[LANE_PAYLOAD-1:0]} : tx_phy1;
  assign rx_phy2 = tx_phy2;

  lpif_link_top u_dut (
    .clk_wr                     (clk_wr),
    .rst                        (rst),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_z_value              (delay_z_value),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .tx_phy2                    (tx_phy2),
    .rx_phy0                    (rx_phy0),
    .rx_phy1                    (rx_phy1),
    .rx_phy2                    (rx_phy2),
    .dstrm_state                (dstrm.state),
    .dstrm_protid               (dstrm.protid),
    .dstrm_data                 (dstrm.data),
    .dstrm_dvalid               (dstrm.dvalid),
    .dstrm_crc                  (dstrm.crc),
    .dstrm_crc_valid            (dstrm.crc_valid),
    .dstrm_valid                (dstrm.valid),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status)
  );

  initial begin
    clk_wr = 1'b0;
    forever #(CLK_PERIOD / 2) clk_wr = ~clk_wr;
  end

  always @(posedge clk_wr) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks and expected values

  task automatic check_flit(input string name, input lpif_flit_t actual,
                            input lpif_flit_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic check_lane(input string name, input lane_word_t actual,
                            input lane_word_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic check_count(input string name, input debug_cnt_t actual,
                             input debug_cnt_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  // Qualifiers only survive with valid set
  function automatic lpif_flit_t upstream_view(input lpif_flit_t f);
    lpif_flit_t u;
    u           = f;
    u.dvalid    = f.dvalid & f.valid;
    u.crc_valid = f.crc_valid & f.valid;
    return u;
  endfunction

  // Lanes 0, 1 and 2 carry flit bits 30..0, 61..31 and 88..62 under the strobe
  function automatic lane_word_t lane_word(input lpif_flit_t f, input int lane,
                                           input logic live);
    lane_word_t w;
    w = '0;
    if (live) begin
      case (lane)
        0:       w = {1'b1, f[30:0]};
        1:       w = {1'b1, f[61:31]};
        default: w = {1'b1, 4'b0000, f[88:62]};
      endcase
    end
    return w;
  endfunction

  function automatic lpif_flit_t random_flit(input logic always_valid);
    lpif_flit_t f;
    f.state     = lpif_state_t'($random(seed));
    f.protid    = lpif_protid_t'($random(seed));
    f.data      = {$random(seed), $random(seed)};
    f.dvalid    = 1'($random(seed));
    f.crc       = lpif_crc_t'($random(seed));
    f.crc_valid = 1'($random(seed));
    f.valid     = always_valid | 1'($random(seed));
    return f;
  endfunction

  ////////////////////////////////////////////////////////////
  // Link cycles

  // Check the flit due now, then drive the next one
  task automatic send_flit(input lpif_flit_t f, input logic pass, input logic tx_live);
    lpif_flit_t exp_f;
    @(negedge clk_wr);
    check_lane("tx_phy0", tx_phy0, lane_word(older_flit, 0, tx_live));
    check_lane("tx_phy1", tx_phy1, lane_word(older_flit, 1, tx_live));
    check_lane("tx_phy2", tx_phy2, lane_word(older_flit, 2, tx_live));
    if (exp_q.size() == LINK_LATENCY) begin
      exp_f = exp_q.pop_front();
      check_flit("ustrm", ustrm, exp_f);
    end
    dstrm = f;
    if (f.valid) begin
      sent_valid++;
    end
    exp_f = '0;
    if (pass) begin
      exp_f = upstream_view(f);
    end
    exp_q.push_back(exp_f);
    older_flit = prev_flit;
    prev_flit  = f;
  endtask

  task automatic drain_link();
    lpif_flit_t exp_f;
    while (exp_q.size() > 0) begin
      @(negedge clk_wr);
      exp_f = exp_q.pop_front();
      check_flit("ustrm", ustrm, exp_f);
      dstrm      = '0;
      older_flit = prev_flit;
      prev_flit  = '0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests

  task automatic test_reset_state();
    check_lane("tx_phy0", tx_phy0, '0);
    check_lane("tx_phy1", tx_phy1, '0);
    check_lane("tx_phy2", tx_phy2, '0);
    check_flit("ustrm", ustrm, '0);
    check_count("tx_downstream_debug_status", tx_downstream_debug_status, '0);
    check_count("rx_upstream_debug_status", rx_upstream_debug_status, '0);
  endtask

  task automatic test_online_delay();
    logic pass;
    int   k;
    for (k = 0; k < TX_DELAY + 8; k++) begin
      pass = (k >= TX_DELAY) && (k >= RX_RISE + RX_DELAY - 1);
      // Strobes show up two edges after the delayed online level
      send_flit(random_flit(1'b1), pass, k >= TX_DELAY + 2);
      if (k == 0) begin
        tx_online = 1'b1;
      end
      if (k == RX_RISE) begin
        rx_online = 1'b1;
      end
    end
    drain_link();
    // Strobes are already up once the receiver is online
    check_count("rx_upstream_debug_status", rx_upstream_debug_status, '0);
    check_count("tx_downstream_debug_status", tx_downstream_debug_status,
                debug_cnt_t'(sent_valid));
  endtask

  task automatic test_loopback_data();
    int k;
    for (k = 0; k < 20; k++) begin
      send_flit(random_flit(1'b0), 1'b1, 1'b1);
    end
    drain_link();
    check_count("tx_downstream_debug_status", tx_downstream_debug_status,
                debug_cnt_t'(sent_valid));
  endtask

  task automatic test_strobe_fault();
    debug_cnt_t rx_before;
    logic       pass;
    int         k;
    rx_before = rx_upstream_debug_status;
    for (k = 0; k < 12; k++) begin
      pass = (k < FAULT_START - 2) || (k >= FAULT_START - 2 + FAULT_LEN);
      send_flit(random_flit(1'b1), pass, 1'b1);
      fault_lane1 = (k >= FAULT_START) && (k < FAULT_START + FAULT_LEN);
    end
    drain_link();
    check_count("rx_upstream_debug_status", rx_upstream_debug_status,
                debug_cnt_t'(rx_before + FAULT_LEN));
  endtask

  task automatic test_offline_drop();
    logic pass;
    logic live;
    int   k;
    for (k = 0; k < 20; k++) begin
      live = (k < DROP_AT + 2) || (k >= RISE_AT + TX_DELAY + 2);
      pass = (k < DROP_AT) || (k >= RISE_AT + TX_DELAY);
      send_flit(random_flit(1'b1), pass, live);
      if (k == DROP_AT) begin
        tx_online = 1'b0;
      end
      if (k == RISE_AT) begin
        tx_online = 1'b1;
      end
    end
    drain_link();
    check_count("tx_downstream_debug_status", tx_downstream_debug_status,
                debug_cnt_t'(sent_valid));
  endtask

  initial begin
    seed          = 32'h5e0c_4dce;
    errors        = 0;
    checks        = 0;
    sent_valid    = 0;
    rst           = 1'b1;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = delay_t'(RX_DELAY);
    delay_z_value = delay_t'(TX_DELAY);
    dstrm         = '0;
    fault_lane1   = 1'b0;
    prev_flit     = '0;
    older_flit    = '0;

    repeat (RESET_CYCLES) @(negedge clk_wr);
    rst = 1'b0;

    test_reset_state();
    test_online_delay();
    test_loopback_data();
    test_strobe_fault();
    test_offline_drop();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: lpif_link.f
verilog/lpif_link_pkg.sv
verilog/lpif_online_delay.sv
verilog/lpif_frame.sv
verilog/lpif_lane_stripe.sv
verilog/lpif_link_top.sv
test/lpif_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the LPIF link testbench with Verilator

rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module lpif_link_tb -f lpif_link.f \
  -o lpif_link_sim \
  && ./obj_dir/lpif_link_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
